/* source/uart_link_consts.svh */
// Data width, memory depth, address width and baud divisor defines for the UART link.
`ifndef UART_LINK_CONSTS_SVH
`define UART_LINK_CONSTS_SVH

`define UL_XLEN      32   // Data word width.
`define UL_MEM_DEPTH 256  // Memory words.
`define UL_ADDR_W    8    // Word address width.

// Clock cycles per serial bit.
`define UL_BAUD_DIV  16

`endif

/* source/uart_link_pkg.sv */
// Word, address and byte-enable types, host opcodes and command engine states.
`include "uart_link_consts.svh"

package uart_link_pkg;

    typedef logic [`UL_XLEN-1:0]   word_t;
    typedef logic [`UL_ADDR_W-1:0] addr_t;
    typedef logic [`UL_XLEN/8-1:0] be_t;

    // Host opcodes, one byte each.
    typedef enum logic [7:0] {
        CMD_WRITE = 8'h01,  // be, addr, four data bytes.
        CMD_READ  = 8'h02,  // addr, reply of four bytes.
        CMD_RUN   = 8'h03,
        CMD_HALT  = 8'h04
    } cmd_e;

    typedef enum logic [2:0] {
        IDLE,
        GET_ARGS,
        MEM_REQ,
        MEM_WAIT,
        SEND
    } eng_state_e;

endpackage

/* source/mem_bus_if.sv */
// Memory request bundle for one bus master, with master and slave modports.
`timescale 1ns/1ps

interface mem_bus_if;

    logic                 req;    // Held until gnt.
    logic                 we;
    uart_link_pkg::addr_t addr;
    uart_link_pkg::word_t wdata;
    uart_link_pkg::be_t   be;
    logic                 gnt;
    uart_link_pkg::word_t rdata;  // Valid one cycle after the grant.

    modport master (
        output req, we, addr, wdata, be,
        input  gnt, rdata
    );

    modport slave (
        input  req, we, addr, wdata, be,
        output gnt, rdata
    );

endinterface

/* source/uart_rx.sv */
// Serial 8N1 receiver with input synchronizer and held output byte.
`timescale 1ns/1ps
`include "uart_link_consts.svh"

module uart_rx(
    input  logic       clk_i,
    input  logic       rst_i,

    input  logic       uart_rx_i,
    input  logic       rx_rdy_i,

    output logic [7:0] rx_data_o,
    output logic       rx_vld_o
);

localparam int DIV   = `UL_BAUD_DIV;
localparam int CNT_W = $clog2(DIV);

typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
} rx_state_e;

rx_state_e        state_q;
logic [1:0]       sync_q;
logic             rx_s;
logic [CNT_W-1:0] cnt_q;
logic [2:0]       bit_q;
logic [7:0]       shift_q;
logic [7:0]       data_q;
logic             vld_q;

assign rx_s      = sync_q[1];
assign rx_data_o = data_q;
assign rx_vld_o  = vld_q;

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        sync_q  <= 2'b11;  // Line idles high.
        state_q <= RX_IDLE;
        cnt_q   <= '0;
        bit_q   <= '0;
        vld_q   <= 1'b0;
    end else begin
        sync_q <= {sync_q[0], uart_rx_i};

        if (vld_q && rx_rdy_i) begin
            vld_q <= 1'b0;
        end

        case (state_q)
            RX_IDLE: begin
                if (!rx_s) begin
                    state_q <= RX_START;
                    cnt_q   <= CNT_W'(DIV / 2 - 1);  // Aim at mid start bit.
                end
            end
            RX_START: begin
                if (cnt_q == '0) begin
                    cnt_q   <= CNT_W'(DIV - 1);
                    bit_q   <= '0;
                    state_q <= rx_s ? RX_IDLE : RX_DATA;  // Glitch rejected.
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
            RX_DATA: begin
                if (cnt_q == '0) begin
                    shift_q <= {rx_s, shift_q[7:1]};  // LSB first.
                    cnt_q   <= CNT_W'(DIV - 1);
                    bit_q   <= bit_q + 1'b1;
                    if (bit_q == 3'd7) begin
                        state_q <= RX_STOP;
                    end
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
            default: begin
                if (cnt_q == '0) begin
                    if (rx_s) begin  // Framing error drops the byte.
                        data_q <= shift_q;
                        vld_q  <= 1'b1;
                    end
                    state_q <= RX_IDLE;
                end else begin
                    cnt_q <= cnt_q - 1'b1;
                end
            end
        endcase
    end
end

endmodule

/* source/uart_tx.sv */
// Serial 8N1 transmitter with a ten-bit frame shifter.
`timescale 1ns/1ps
`include "uart_link_consts.svh"

module uart_tx(
    input  logic       clk_i,
    input  logic       rst_i,

    input  logic [7:0] tx_data_i,
    input  logic       tx_vld_i,

    output logic       uart_tx_o,
    output logic       tx_rdy_o
);

localparam int DIV   = `UL_BAUD_DIV;
localparam int CNT_W = $clog2(DIV);

logic             busy_q;
logic [9:0]       frame_q;
logic [CNT_W-1:0] cnt_q;
logic [3:0]       bits_q;

assign tx_rdy_o  = ~busy_q;
assign uart_tx_o = frame_q[0];

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        busy_q  <= 1'b0;
        frame_q <= '1;  // Idle high.
        cnt_q   <= '0;
        bits_q  <= '0;
    end else if (!busy_q) begin
        if (tx_vld_i) begin
            frame_q <= {1'b1, tx_data_i, 1'b0};  // Stop, data, start.
            busy_q  <= 1'b1;
            cnt_q   <= CNT_W'(DIV - 1);
            bits_q  <= 4'd9;
        end
    end else if (cnt_q == '0) begin
        if (bits_q == '0) begin
            busy_q <= 1'b0;  // Stop bit done.
        end else begin
            frame_q <= {1'b1, frame_q[9:1]};
            bits_q  <= bits_q - 1'b1;
            cnt_q   <= CNT_W'(DIV - 1);
        end
    end else begin
        cnt_q <= cnt_q - 1'b1;
    end
end

endmodule

/* source/cmd_engine.sv */
// Host command decoder driving memory accesses, read replies and the core run level.
`timescale 1ns/1ps
`include "uart_link_consts.svh"

module cmd_engine(
    input  logic       clk_i,
    input  logic       rst_i,

    input  logic [7:0] rx_data_i,
    input  logic       rx_vld_i,
    output logic       rx_rdy_o,

    output logic [7:0] tx_data_o,
    output logic       tx_vld_o,
    input  logic       tx_rdy_i,

    mem_bus_if.master  mem,

    output logic       core_run_o
);

uart_link_pkg::eng_state_e state_q;

logic                 is_wr_q;
logic [2:0]           arg_cnt_q;
logic [1:0]           byte_cnt_q;
uart_link_pkg::be_t   be_q;
uart_link_pkg::addr_t addr_q;
uart_link_pkg::word_t data_q;
logic                 run_q;
logic                 rx_take;
logic                 args_done;

// ****************************************
// Handshakes and memory request
// ****************************************

assign rx_rdy_o = (state_q == uart_link_pkg::IDLE) || (state_q == uart_link_pkg::GET_ARGS);
assign rx_take  = rx_vld_i & rx_rdy_o;

assign args_done = is_wr_q ? (arg_cnt_q == 3'd5) : (arg_cnt_q == 3'd1);

assign tx_vld_o  = (state_q == uart_link_pkg::SEND);
assign tx_data_o = data_q[7:0];  // LSB first.

assign mem.req   = (state_q == uart_link_pkg::MEM_REQ);
assign mem.we    = is_wr_q;
assign mem.addr  = addr_q;
assign mem.wdata = data_q;
assign mem.be    = be_q;

assign core_run_o = run_q;

// ****************************************
// Command FSM
// ****************************************

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        state_q    <= uart_link_pkg::IDLE;
        is_wr_q    <= 1'b0;
        arg_cnt_q  <= '0;
        byte_cnt_q <= '0;
        run_q      <= 1'b0;
    end else begin
        case (state_q)
            uart_link_pkg::IDLE: begin
                if (rx_take) begin
                    case (rx_data_i)
                        uart_link_pkg::CMD_WRITE: begin
                            is_wr_q   <= 1'b1;
                            arg_cnt_q <= 3'd0;
                            state_q   <= uart_link_pkg::GET_ARGS;
                        end
                        uart_link_pkg::CMD_READ: begin
                            is_wr_q   <= 1'b0;
                            arg_cnt_q <= 3'd1;  // Address byte only.
                            state_q   <= uart_link_pkg::GET_ARGS;
                        end
                        uart_link_pkg::CMD_RUN:  run_q <= 1'b1;
                        uart_link_pkg::CMD_HALT: run_q <= 1'b0;
                        default: ;  // Unknown opcode is dropped.
                    endcase
                end
            end
            uart_link_pkg::GET_ARGS: begin
                if (rx_take) begin
                    case (arg_cnt_q)
                        3'd0:    be_q   <= uart_link_pkg::be_t'(rx_data_i);
                        3'd1:    addr_q <= uart_link_pkg::addr_t'(rx_data_i);
                        default: data_q <= {rx_data_i, data_q[`UL_XLEN-1:8]};
                    endcase
                    arg_cnt_q <= arg_cnt_q + 1'b1;
                    if (args_done) begin
                        state_q <= uart_link_pkg::MEM_REQ;
                    end
                end
            end
            uart_link_pkg::MEM_REQ: begin
                if (mem.gnt) begin
                    state_q <= is_wr_q ? uart_link_pkg::IDLE : uart_link_pkg::MEM_WAIT;
                end
            end
            uart_link_pkg::MEM_WAIT: begin
                data_q     <= mem.rdata;
                byte_cnt_q <= '0;
                state_q    <= uart_link_pkg::SEND;
            end
            default: begin
                if (tx_rdy_i) begin
                    data_q     <= data_q >> 8;
                    byte_cnt_q <= byte_cnt_q + 1'b1;
                    if (byte_cnt_q == 2'd3) begin
                        state_q <= uart_link_pkg::IDLE;
                    end
                end
            end
        endcase
    end
end

endmodule

/* source/mem_arbiter.sv */
// Fixed-priority arbiter sharing one memory port between the core and the command engine.
`timescale 1ns/1ps

module mem_arbiter(
    input  logic      clk_i,
    input  logic      rst_i,

    mem_bus_if.slave  core,
    mem_bus_if.slave  eng,
    mem_bus_if.master mem
);

logic core_own_q;
logic eng_own_q;

// Core always wins.
assign core.gnt = core.req & mem.gnt;
assign eng.gnt  = eng.req & ~core.req & mem.gnt;

assign mem.req   = core.req | eng.req;
assign mem.we    = core.req ? core.we    : eng.we;
assign mem.addr  = core.req ? core.addr  : eng.addr;
assign mem.wdata = core.req ? core.wdata : eng.wdata;
assign mem.be    = core.req ? core.be    : eng.be;

always_ff @(posedge clk_i) begin
    if (rst_i) begin
        core_own_q <= 1'b0;
        eng_own_q  <= 1'b0;
    end else begin
        core_own_q <= core.gnt;  // Owner of last cycle's access.
        eng_own_q  <= eng.gnt;
    end
end

assign core.rdata = core_own_q ? mem.rdata : '0;
assign eng.rdata  = eng_own_q  ? mem.rdata : '0;

endmodule

/* source/word_ram.sv */
// Single-port word memory with byte write enables and registered read data.
`timescale 1ns/1ps
`include "uart_link_consts.svh"

module word_ram(
    input logic      clk_i,

    mem_bus_if.slave mem
);

uart_link_pkg::word_t ram [`UL_MEM_DEPTH];
uart_link_pkg::word_t rdata_q;

assign mem.gnt   = 1'b1;  // Masters already serialized upstream.
assign mem.rdata = rdata_q;

always_ff @(posedge clk_i) begin
    if (mem.req) begin
        if (mem.we) begin
            for (int i = 0; i < `UL_XLEN / 8; i++) begin
                if (mem.be[i]) begin
                    ram[mem.addr][i*8 +: 8] <= mem.wdata[i*8 +: 8];
                end
            end
        end else begin
            rdata_q <= ram[mem.addr];
        end
    end
end

endmodule

/* source/uart_link_top.sv */
// Top level joining UART receiver, transmitter, command engine, arbiter and word memory.
`timescale 1ns/1ps

module uart_link_top(
    input  logic                 clk_i,
    input  logic                 rst_i,

    input  logic                 uart_rx_i,
    output logic                 uart_tx_o,

    input  logic                 core_req_i,
    input  logic                 core_we_i,
    input  uart_link_pkg::addr_t core_addr_i,
    input  uart_link_pkg::word_t core_wdata_i,
    input  uart_link_pkg::be_t   core_be_i,
    output logic                 core_gnt_o,
    output uart_link_pkg::word_t core_rdata_o,

    output logic                 core_run_o
);

logic [7:0] rx_data;
logic       rx_vld;
logic       rx_rdy;

logic [7:0] tx_data;
logic       tx_vld;
logic       tx_rdy;

mem_bus_if core_bus();
mem_bus_if eng_bus();
mem_bus_if ram_bus();

// ****************************************
// Core data port
// ****************************************

assign core_bus.req   = core_req_i;
assign core_bus.we    = core_we_i;
assign core_bus.addr  = core_addr_i;
assign core_bus.wdata = core_wdata_i;
assign core_bus.be    = core_be_i;

assign core_gnt_o   = core_bus.gnt;
assign core_rdata_o = core_bus.rdata;

// ****************************************
// Serial link and command path
// ****************************************

uart_rx uart_rx(
    .clk_i(clk_i),
    .rst_i(rst_i),

    .uart_rx_i(uart_rx_i),
    .rx_rdy_i(rx_rdy),

    .rx_data_o(rx_data),
    .rx_vld_o(rx_vld)
);

uart_tx uart_tx(
    .clk_i(clk_i),
    .rst_i(rst_i),

    .tx_data_i(tx_data),
    .tx_vld_i(tx_vld),

    .uart_tx_o(uart_tx_o),
    .tx_rdy_o(tx_rdy)
);

cmd_engine cmd_engine(
    .clk_i(clk_i),
    .rst_i(rst_i),

    .rx_data_i(rx_data),
    .rx_vld_i(rx_vld),
    .rx_rdy_o(rx_rdy),

    .tx_data_o(tx_data),
    .tx_vld_o(tx_vld),
    .tx_rdy_i(tx_rdy),

    .mem(eng_bus.master),

    .core_run_o(core_run_o)
);

mem_arbiter mem_arbiter(
    .clk_i(clk_i),
    .rst_i(rst_i),

    .core(core_bus.slave),
    .eng(eng_bus.slave),
    .mem(ram_bus.master)
);

word_ram word_ram(
    .clk_i(clk_i),

    .mem(ram_bus.slave)
);

endmodule

/* dv/uart_link_tb.sv */
// Testbench with serial host, core port model and stimulus file checks for the UART link.
`timescale 1ns/1ps
`include "uart_link_consts.svh"

module uart_link_tb;

localparam int DIV       = `UL_BAUD_DIV;
localparam int MAX_STEPS = 40;

logic                 clk;
logic                 rst;
logic                 rx_line;
logic                 tx_line;
logic                 core_req;
logic                 core_we;
uart_link_pkg::addr_t core_addr;
uart_link_pkg::word_t core_wdata;
uart_link_pkg::be_t   core_be;
logic                 core_gnt;
uart_link_pkg::word_t core_rdata;
logic                 core_run;

logic [31:0]          stim [0:MAX_STEPS*4-1];  // Rows of op, a, b, c.
uart_link_pkg::word_t model [`UL_MEM_DEPTH];
int                   cycles    = 0;
int                   limit     = 0;
int                   errors    = 0;
int                   step_errs = 0;
int                   tests     = 0;
int                   failed    = 0;

uart_link_top dut(
    .clk_i(clk),
    .rst_i(rst),
    .uart_rx_i(rx_line),
    .uart_tx_o(tx_line),
    .core_req_i(core_req),
    .core_we_i(core_we),
    .core_addr_i(core_addr),
    .core_wdata_i(core_wdata),
    .core_be_i(core_be),
    .core_gnt_o(core_gnt),
    .core_rdata_o(core_rdata),
    .core_run_o(core_run)
);

initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
end

always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("STATUS: FAIL");
        $finish;
    end
end

// ****************************************
// Checks and bookkeeping
// ****************************************

task automatic check(input string msg, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("mismatch at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
        errors++;
        step_errs++;
    end
endtask

task automatic report_test(input string name);
    tests++;
    if (step_errs == 0) begin
        $display("test %0d %s: ok", tests, name);
    end else begin
        $display("test %0d %s: failed", tests, name);
        failed++;
    end
    step_errs = 0;
endtask

function automatic uart_link_pkg::word_t merge_bytes(input uart_link_pkg::word_t old,
                                                     input uart_link_pkg::word_t data,
                                                     input uart_link_pkg::be_t   be);
    uart_link_pkg::word_t res;
    res = old;
    for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
            res[i*8 +: 8] = data[i*8 +: 8];
        end
    end
    return res;
endfunction

function automatic int step_cost(input logic [31:0] op, input logic [31:0] c);
    case (op)
        32'd1:        return 7 * 200;  // About 200 cycles per serial byte.
        32'd2:        return 6 * 200;
        32'd3, 32'd4: return 10;
        32'd5:        return 200;
        32'd6:        return 7 * 200 + int'(c);
        default:      return 0;
    endcase
endfunction

// ****************************************
// Serial host and core port
// ****************************************

task automatic send_byte(input logic [7:0] data);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int i = 0; i < 10; i++) begin
        rx_line = frame[i];
        repeat (DIV) @(negedge clk);
    end
endtask

task automatic recv_byte(output logic [7:0] data);
    while (tx_line !== 1'b0) @(negedge clk);
    repeat (DIV / 2) @(negedge clk);  // Middle of the start bit.
    for (int i = 0; i < 8; i++) begin
        repeat (DIV) @(negedge clk);
        data[i] = tx_line;
    end
    repeat (DIV) @(negedge clk);
    check("reply stop bit", tx_line, 1'b1);
endtask

task automatic host_write(input uart_link_pkg::be_t be, input uart_link_pkg::addr_t addr,
                          input uart_link_pkg::word_t data);
    send_byte(uart_link_pkg::CMD_WRITE);
    send_byte(8'(be));
    send_byte(addr);
    for (int i = 0; i < 4; i++) begin
        send_byte(data[i*8 +: 8]);  // LSB first.
    end
    model[addr] = merge_bytes(model[addr], data, be);
endtask

task automatic host_read(input uart_link_pkg::addr_t addr, output uart_link_pkg::word_t data);
    uart_link_pkg::word_t got;
    logic [7:0]           rx_byte;
    fork
        begin
            send_byte(uart_link_pkg::CMD_READ);
            send_byte(addr);
        end
        for (int i = 0; i < 4; i++) begin
            recv_byte(rx_byte);
            got[i*8 +: 8] = rx_byte;
        end
    join
    data = got;
endtask

task automatic core_access(input logic we, input uart_link_pkg::be_t be,
                           input uart_link_pkg::addr_t addr, input uart_link_pkg::word_t wdata,
                           output uart_link_pkg::word_t rdata);
    core_req   = 1'b1;
    core_we    = we;
    core_be    = be;
    core_addr  = addr;
    core_wdata = wdata;
    #1;
    while (core_gnt !== 1'b1) begin
        @(negedge clk);
        #1;
    end
    @(negedge clk);
    core_req = 1'b0;
    core_we  = 1'b0;
    rdata    = core_rdata;  // One cycle after the grant.
endtask

// The core holds the memory through the whole host write and for busy cycles after it.
task automatic contend(input uart_link_pkg::addr_t addr, input uart_link_pkg::word_t data,
                       input int busy);
    logic host_done;
    int   left;
    host_done = 1'b0;
    left      = busy;
    fork
        begin
            host_write(4'hf, addr, data);
            host_done = 1'b1;
        end
        begin
            core_we   = 1'b0;
            core_addr = addr + 1'b1;
            core_req  = 1'b1;
            while (left > 0) begin
                #1;
                check("core grant under contention", core_gnt, 1'b1);
                if (host_done) begin
                    left--;
                end
                @(negedge clk);
            end
            core_req = 1'b0;
        end
    join
endtask

// ****************************************
// Test sequence
// ****************************************

initial begin
    uart_link_pkg::word_t got;
    uart_link_pkg::word_t fill;
    logic [31:0]          op;
    logic [31:0]          a;
    logic [31:0]          b;
    logic [31:0]          c;

    rst        = 1'b1;
    rx_line    = 1'b1;
    core_req   = 1'b0;
    core_we    = 1'b0;
    core_addr  = '0;
    core_wdata = '0;
    core_be    = '0;
    void'($urandom(32'hd3a4));

    for (int i = 0; i < MAX_STEPS * 4; i++) begin
        stim[i] = '0;
    end
    $readmemh("dv/uart_link_stimulus.txt", stim);
    limit = 8 + `UL_MEM_DEPTH * 4;
    for (int s = 0; s < MAX_STEPS; s++) begin
        limit += step_cost(stim[s*4], stim[s*4+3]);
    end
    limit = limit * 3 / 2;

    repeat (8) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check("run level after reset", core_run, 1'b0);
    check("serial idle after reset", tx_line, 1'b1);
    check("core grant after reset", core_gnt, 1'b0);
    report_test("reset state");

    for (int i = 0; i < `UL_MEM_DEPTH; i++) begin
        fill = $urandom;
        core_access(1'b1, 4'hf, uart_link_pkg::addr_t'(i), fill, got);
        model[i] = fill;
    end
    report_test("memory fill");

    for (int s = 0; s < MAX_STEPS; s++) begin
        op = stim[s*4];
        a  = stim[s*4+1];
        b  = stim[s*4+2];
        c  = stim[s*4+3];
        if (op == 0) begin
            break;
        end
        case (op)
            32'd1: host_write(uart_link_pkg::be_t'(a), uart_link_pkg::addr_t'(b), c);
            32'd2: begin
                host_read(uart_link_pkg::addr_t'(a), got);
                check("host read against model", got, model[a[7:0]]);
                if (c[0]) begin
                    check("host read against file", got, b);
                end
            end
            32'd3: begin
                core_access(1'b1, uart_link_pkg::be_t'(a), uart_link_pkg::addr_t'(b), c, got);
                model[b[7:0]] = merge_bytes(model[b[7:0]], c, uart_link_pkg::be_t'(a));
            end
            32'd4: begin
                core_access(1'b0, 4'h0, uart_link_pkg::addr_t'(a), '0, got);
                check("core read against model", got, model[a[7:0]]);
                if (c[0]) begin
                    check("core read against file", got, b);
                end
            end
            32'd5: begin
                send_byte(a[7:0]);
                check("run level", core_run, b[0]);
            end
            32'd6: contend(uart_link_pkg::addr_t'(a), b, int'(c));
            default: begin
                $display("stimulus row %0d holds an unknown step code %0h", s, op);
                errors++;
                step_errs++;
            end
        endcase
        report_test($sformatf("step %0d (code %0d)", s, op));
    end

    $display("tests %0d, failed %0d, mismatches and errors %0d", tests, failed, errors);
    if (errors == 0) begin
        $display("STATUS: PASS");
    end else begin
        $display("STATUS: FAIL");
    end
    $finish;
end

endmodule

/* dv/uart_link_stimulus.txt */
// Columns in hex: code a b c. 1 host write (be, addr, data), 2 host read (addr, expect, use),
// 3 core write (be, addr, data), 4 core read (addr, expect, use), 5 raw opcode (byte, run),
// 6 contend (addr, data, core busy cycles), 0 end of steps.
// Full write, then host and core read back.
1 f 20 a5c3e17b
2 20 a5c3e17b 1
4 20 a5c3e17b 1
// Partial byte enables on a random word and on a known word.
1 5 31 11223344
2 31 0 0
4 31 0 0
1 f 21 deadbeef
1 6 21 00cafe00
2 21 decafeef 1
// Core write seen by the host.
3 f 50 13572468
2 50 13572468 1
// Host write while the core holds the memory.
6 40 0badf00d 44c
2 40 0badf00d 1
4 40 0badf00d 1
// Run level, halt and an unknown opcode.
5 3 1 0
5 4 0 0
5 3 1 0
5 7e 1 0
2 20 a5c3e17b 1
5 4 0 0
0 0 0 0

/* src.f */
+incdir+source
source/uart_link_pkg.sv
source/mem_bus_if.sv
source/uart_rx.sv
source/uart_tx.sv
source/cmd_engine.sv
source/mem_arbiter.sv
source/word_ram.sv
source/uart_link_top.sv
dv/uart_link_tb.sv
